// ==== include/debug_settings.svh ====
`ifndef DEBUG_SETTINGS_SVH
`define DEBUG_SETTINGS_SVH

// Shared width of read data, instructions, cycle counter and status word.
`define DBG_WORD_W              32

`define DBG_CMD_L               8'h4C   // 'L' load program.
`define DBG_CMD_F               8'h46   // 'F' flush.
`define DBG_CMD_E               8'h45   // 'E' run.
`define DBG_CMD_S               8'h53   // 'S' step mode, or stop while stepping.
`define DBG_CMD_N               8'h4E   // 'N' next step.

`define DBG_PREFIX_INFO         8'h49   // 'I'.
`define DBG_PREFIX_ERROR        8'h45   // 'E'.

// Info codes.
`define DBG_CODE_LOAD_DONE      8'h01
`define DBG_CODE_END_PROGRAM    8'h02
`define DBG_CODE_END_STEP       8'h03

// Error codes.
`define DBG_CODE_UNKNOWN_CMD    8'h04
`define DBG_CODE_MEM_FULL       8'h05
`define DBG_CODE_EMPTY_PROGRAM  8'h06

`define DBG_INSTR_HALT          32'hFFFF_FFFF

`endif

// ==== rtl/debug_pkg.sv ====
`default_nettype none

`include "debug_settings.svh"

package debug_pkg;

    typedef logic [`DBG_WORD_W-1:0] word_t;

    typedef enum logic [4:0] {
        ST_BOOT,
        ST_IDLE,
        ST_DECODE,
        ST_FLUSH,
        ST_LOAD_IDLE,
        ST_LOAD,
        ST_RUN,
        ST_STEP,
        ST_PRINT_REQ,
        ST_RUN_IDLE,
        ST_STEP_READ,
        ST_STEP_DECODE,
        ST_START_HOLD,
        ST_START_TRANS,
        ST_WAIT_RD,
        ST_WAIT_WR,
        ST_WAIT_PRINT
    } seq_state_e;

    typedef enum logic [2:0] {
        MSG_LOAD_DONE,
        MSG_END_PROGRAM,
        MSG_END_STEP,
        MSG_UNKNOWN_CMD,
        MSG_MEM_FULL,
        MSG_EMPTY_PROGRAM
    } status_msg_e;

endpackage

`default_nettype wire

// ==== rtl/debug_ctl_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface debug_ctl_if;
    import debug_pkg::*;

    logic        cycle_clear;       // Reload cycle counter to 1.
    logic        cycle_step;        // Count one enabled cycle.
    logic        step_mode_load;
    logic        step_mode_value;
    logic        instr_capture;     // Latch read data and pulse instruction write.
    logic        instr_clear;
    logic        msg_load;
    status_msg_e msg_code;
    logic        instr_is_halt;
    logic        step_mode;

    modport seq (
        output cycle_clear, cycle_step, step_mode_load, step_mode_value,
        output instr_capture, instr_clear, msg_load, msg_code,
        input  instr_is_halt, step_mode
    );

    modport regs (
        input  cycle_clear, cycle_step, step_mode_load, step_mode_value,
        input  instr_capture, instr_clear, msg_load, msg_code,
        output instr_is_halt, step_mode
    );

endinterface

`default_nettype wire

// ==== rtl/debug_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "debug_settings.svh"

module debug_sequencer (
    input  logic              i_clk,
    input  logic              i_reset,
    input  logic              i_instr_mem_empty,
    input  logic              i_instr_mem_full,
    input  logic              i_program_end,
    input  logic              i_uart_rd_end,
    input  logic              i_uart_wr_end,
    input  logic              i_reg_print_end,
    input  debug_pkg::word_t  i_uart_rd_data,
    debug_ctl_if.seq          ctl,
    output logic              o_start_uart_rd,
    output logic              o_start_uart_wr,
    output logic              o_start_reg_print,
    output logic              o_mips_flush,
    output logic              o_mips_clear_program,
    output logic              o_mips_enabled
);
    import debug_pkg::*;

    seq_state_e state, state_next;
    seq_state_e return_state, return_state_next;
    logic       start_rd, start_rd_next;
    logic       start_wr, start_wr_next;
    logic       start_print, start_print_next;
    logic       mips_flush, mips_flush_next;
    logic       clear_program, clear_program_next;
    logic       mips_enabled, mips_enabled_next;
    logic       rd_req;
    logic       msg_req;
    logic       print_req;

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            state         <= ST_BOOT;
            return_state  <= ST_IDLE;
            start_rd      <= 1'b0;
            start_wr      <= 1'b0;
            start_print   <= 1'b0;
            mips_flush    <= 1'b0;
            clear_program <= 1'b0;
            mips_enabled  <= 1'b0;
        end
        else
        begin
            state         <= state_next;
            return_state  <= return_state_next;
            start_rd      <= start_rd_next;
            start_wr      <= start_wr_next;
            start_print   <= start_print_next;
            mips_flush    <= mips_flush_next;
            clear_program <= clear_program_next;
            mips_enabled  <= mips_enabled_next;
        end
    end

    always_comb
    begin
        state_next          = state;
        return_state_next   = return_state;
        start_rd_next       = start_rd;
        start_wr_next       = start_wr;
        start_print_next    = start_print;
        mips_flush_next     = mips_flush;
        clear_program_next  = clear_program;
        mips_enabled_next   = mips_enabled;
        rd_req              = 1'b0;
        msg_req             = 1'b0;
        print_req           = 1'b0;
        ctl.cycle_clear     = 1'b0;
        ctl.cycle_step      = 1'b0;
        ctl.step_mode_load  = 1'b0;
        ctl.step_mode_value = 1'b0;
        ctl.instr_capture   = 1'b0;
        ctl.instr_clear     = 1'b0;
        ctl.msg_load        = 1'b0;
        ctl.msg_code        = MSG_LOAD_DONE;

        case (state)
            ST_BOOT:
            begin
                state_next = ST_IDLE;
            end

            ST_IDLE:
            begin
                ctl.cycle_clear    = 1'b1;
                mips_enabled_next  = 1'b0;
                mips_flush_next    = 1'b0;
                clear_program_next = 1'b0;
                rd_req             = 1'b1;
                return_state_next  = ST_DECODE;
            end

            ST_DECODE:
            begin
                case (i_uart_rd_data[7:0])
                    `DBG_CMD_L:
                    begin
                        mips_flush_next    = 1'b1;
                        clear_program_next = 1'b1;
                        return_state_next  = ST_LOAD_IDLE;
                        state_next         = ST_FLUSH;
                    end
                    `DBG_CMD_F:
                    begin
                        mips_flush_next    = 1'b1;
                        clear_program_next = 1'b1;
                        return_state_next  = ST_IDLE;
                        state_next         = ST_FLUSH;
                    end
                    `DBG_CMD_E:
                    begin
                        mips_flush_next    = 1'b1;
                        ctl.step_mode_load = 1'b1;
                        return_state_next  = ST_RUN;
                        state_next         = ST_FLUSH;
                    end
                    `DBG_CMD_S:
                    begin
                        mips_flush_next     = 1'b1;
                        ctl.step_mode_load  = 1'b1;
                        ctl.step_mode_value = 1'b1;
                        return_state_next   = ST_PRINT_REQ;  // Show registers before step 1.
                        state_next          = ST_FLUSH;
                    end
                    default:
                    begin
                        msg_req           = 1'b1;
                        ctl.msg_code      = MSG_UNKNOWN_CMD;
                        return_state_next = ST_IDLE;
                    end
                endcase
            end

            ST_FLUSH:
            begin
                mips_flush_next    = 1'b0;
                clear_program_next = 1'b0;
                ctl.instr_clear    = 1'b1;  // Next load starts from a non-HALT latch.
                state_next         = return_state;
            end

            ST_LOAD_IDLE:
            begin
                if (ctl.instr_is_halt)
                begin
                    msg_req           = 1'b1;
                    ctl.msg_code      = MSG_LOAD_DONE;
                    return_state_next = ST_IDLE;
                end
                else if (!i_instr_mem_full)
                begin
                    rd_req            = 1'b1;
                    return_state_next = ST_LOAD;
                end
                else
                begin
                    msg_req           = 1'b1;
                    ctl.msg_code      = MSG_MEM_FULL;
                    return_state_next = ST_IDLE;
                end
            end

            ST_LOAD:
            begin
                ctl.instr_capture = 1'b1;
                state_next        = ST_LOAD_IDLE;
            end

            ST_RUN:
            begin
                if (i_instr_mem_empty)
                begin
                    mips_enabled_next = 1'b0;
                    msg_req           = 1'b1;
                    ctl.msg_code      = MSG_EMPTY_PROGRAM;
                    return_state_next = ST_IDLE;
                end
                else if (i_program_end)
                    state_next = ST_PRINT_REQ;
                else
                begin
                    mips_enabled_next = 1'b1;
                    ctl.cycle_step    = 1'b1;
                end
            end

            ST_STEP:
            begin
                if (i_instr_mem_empty)
                begin
                    msg_req           = 1'b1;
                    ctl.msg_code      = MSG_EMPTY_PROGRAM;
                    return_state_next = ST_IDLE;
                end
                else
                begin
                    mips_enabled_next = 1'b1;  // Dropped again in ST_PRINT_REQ.
                    ctl.cycle_step    = 1'b1;
                    state_next        = ST_PRINT_REQ;
                end
            end

            ST_PRINT_REQ:
            begin
                mips_enabled_next = 1'b0;
                print_req         = 1'b1;
            end

            ST_RUN_IDLE:
            begin
                if (i_program_end)
                begin
                    msg_req           = 1'b1;
                    ctl.msg_code      = MSG_END_PROGRAM;
                    return_state_next = ST_IDLE;
                end
                else if (ctl.step_mode)
                begin
                    msg_req           = 1'b1;
                    ctl.msg_code      = MSG_END_STEP;
                    return_state_next = ST_STEP_READ;
                end
                else
                    state_next = ST_RUN;
            end

            ST_STEP_READ:
            begin
                rd_req            = 1'b1;
                return_state_next = ST_STEP_DECODE;
            end

            ST_STEP_DECODE:
            begin
                case (i_uart_rd_data[7:0])
                    `DBG_CMD_S: state_next = ST_IDLE;
                    `DBG_CMD_N: state_next = ST_STEP;
                    default:
                    begin
                        msg_req           = 1'b1;
                        ctl.msg_code      = MSG_UNKNOWN_CMD;
                        return_state_next = ST_STEP_READ;
                    end
                endcase
            end

            // Start strobes are high through HOLD and TRANS.
            ST_START_HOLD:
            begin
                state_next = ST_START_TRANS;
            end

            ST_START_TRANS:
            begin
                start_rd_next    = 1'b0;
                start_wr_next    = 1'b0;
                start_print_next = 1'b0;
                if (start_rd)
                    state_next = ST_WAIT_RD;
                else if (start_wr)
                    state_next = ST_WAIT_WR;
                else
                    state_next = ST_WAIT_PRINT;
            end

            ST_WAIT_RD:
            begin
                if (i_uart_rd_end)
                    state_next = return_state;
            end

            ST_WAIT_WR:
            begin
                if (i_uart_wr_end)
                    state_next = return_state;
            end

            ST_WAIT_PRINT:
            begin
                if (i_reg_print_end)
                    state_next = ST_RUN_IDLE;
            end

            default:
            begin
                state_next = ST_IDLE;
            end
        endcase

        if (rd_req)
        begin
            start_rd_next = 1'b1;
            state_next    = ST_START_HOLD;
        end
        if (msg_req)
        begin
            ctl.msg_load  = 1'b1;  // Word updates on the same edge as the write strobe.
            start_wr_next = 1'b1;
            state_next    = ST_START_HOLD;
        end
        if (print_req)
        begin
            start_print_next = 1'b1;
            state_next       = ST_START_HOLD;
        end
    end

    assign o_start_uart_rd      = start_rd;
    assign o_start_uart_wr      = start_wr;
    assign o_start_reg_print    = start_print;
    assign o_mips_flush         = mips_flush;
    assign o_mips_clear_program = clear_program;
    assign o_mips_enabled       = mips_enabled;

endmodule

`default_nettype wire

// ==== rtl/debug_status_regs.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "debug_settings.svh"

module debug_status_regs (
    input  logic              i_clk,
    input  logic              i_reset,
    input  debug_pkg::word_t  i_uart_rd_data,
    debug_ctl_if.regs         ctl,
    output debug_pkg::word_t  o_cycle_count,
    output debug_pkg::word_t  o_mips_instr,
    output debug_pkg::word_t  o_status_word,
    output logic              o_mips_instr_wr
);
    import debug_pkg::*;

    logic  step_mode;
    logic  instr_wr;
    word_t cycle_count;
    word_t instr_latch;
    word_t status_word;

    function automatic word_t encode_status(input status_msg_e msg);
        logic [7:0] prefix;
        logic [7:0] code;
        prefix = `DBG_PREFIX_INFO;
        case (msg)
            MSG_LOAD_DONE:   code = `DBG_CODE_LOAD_DONE;
            MSG_END_PROGRAM: code = `DBG_CODE_END_PROGRAM;
            MSG_END_STEP:    code = `DBG_CODE_END_STEP;
            MSG_UNKNOWN_CMD:
            begin
                prefix = `DBG_PREFIX_ERROR;
                code   = `DBG_CODE_UNKNOWN_CMD;
            end
            MSG_MEM_FULL:
            begin
                prefix = `DBG_PREFIX_ERROR;
                code   = `DBG_CODE_MEM_FULL;
            end
            default:
            begin
                prefix = `DBG_PREFIX_ERROR;
                code   = `DBG_CODE_EMPTY_PROGRAM;
            end
        endcase
        return {prefix, {(`DBG_WORD_W - 16){1'b0}}, code};
    endfunction

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            step_mode   <= 1'b0;
            instr_wr    <= 1'b0;
            cycle_count <= '0;
        end
        else
        begin
            instr_wr <= ctl.instr_capture;  // One write per captured word.
            if (ctl.step_mode_load)
                step_mode <= ctl.step_mode_value;
            if (ctl.cycle_clear)
                cycle_count <= word_t'(1);
            else if (ctl.cycle_step)
                cycle_count <= cycle_count + word_t'(1);
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (ctl.instr_clear)
            instr_latch <= '0;
        else if (ctl.instr_capture)
            instr_latch <= i_uart_rd_data;
        if (ctl.msg_load)
            status_word <= encode_status(ctl.msg_code);
    end

    assign ctl.instr_is_halt = (instr_latch == `DBG_INSTR_HALT);
    assign ctl.step_mode     = step_mode;

    assign o_cycle_count   = cycle_count;
    assign o_mips_instr    = instr_latch;
    assign o_mips_instr_wr = instr_wr;
    assign o_status_word   = status_word;

endmodule

`default_nettype wire

// ==== rtl/debug_control_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "debug_settings.svh"

module debug_control_top (
    input  logic                   i_clk,
    input  logic                   i_reset,
    input  logic                   i_instr_mem_empty,
    input  logic                   i_instr_mem_full,
    input  logic                   i_program_end,
    input  logic                   i_uart_rd_end,
    input  logic                   i_uart_wr_end,
    input  logic                   i_reg_print_end,
    input  logic [`DBG_WORD_W-1:0] i_uart_rd_data,
    output logic                   o_start_uart_rd,
    output logic                   o_start_uart_wr,
    output logic [`DBG_WORD_W-1:0] o_uart_wr_data,
    output logic                   o_start_reg_print,
    output logic                   o_mips_flush,
    output logic                   o_mips_clear_program,
    output logic                   o_mips_enabled,
    output logic                   o_mips_instr_wr,
    output logic [`DBG_WORD_W-1:0] o_mips_instr,
    output logic [`DBG_WORD_W-1:0] o_cycle_count
);

    debug_ctl_if u_ctl_if ();

    debug_sequencer u_sequencer (
        .i_clk                (i_clk),
        .i_reset              (i_reset),
        .i_instr_mem_empty    (i_instr_mem_empty),
        .i_instr_mem_full     (i_instr_mem_full),
        .i_program_end        (i_program_end),
        .i_uart_rd_end        (i_uart_rd_end),
        .i_uart_wr_end        (i_uart_wr_end),
        .i_reg_print_end      (i_reg_print_end),
        .i_uart_rd_data       (i_uart_rd_data),
        .ctl                  (u_ctl_if.seq),
        .o_start_uart_rd      (o_start_uart_rd),
        .o_start_uart_wr      (o_start_uart_wr),
        .o_start_reg_print    (o_start_reg_print),
        .o_mips_flush         (o_mips_flush),
        .o_mips_clear_program (o_mips_clear_program),
        .o_mips_enabled       (o_mips_enabled)
    );

    debug_status_regs u_status_regs (
        .i_clk           (i_clk),
        .i_reset         (i_reset),
        .i_uart_rd_data  (i_uart_rd_data),
        .ctl             (u_ctl_if.regs),
        .o_cycle_count   (o_cycle_count),
        .o_mips_instr    (o_mips_instr),
        .o_status_word   (o_uart_wr_data),  // Status word goes straight to the UART.
        .o_mips_instr_wr (o_mips_instr_wr)
    );

endmodule

`default_nettype wire

// ==== dv/tb_debug_control.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "debug_settings.svh"

module tb_debug_control;
    import debug_pkg::*;

    localparam int case_depth   = 64;
    localparam int unit_rd      = 0;
    localparam int unit_wr      = 1;
    localparam int unit_print   = 2;
    localparam logic [7:0] kind_command = 8'h01;
    localparam logic [7:0] kind_load    = 8'h02;
    localparam logic [7:0] kind_levels  = 8'h03;
    localparam logic [7:0] kind_run     = 8'h04;
    localparam logic [7:0] kind_status  = 8'h05;
    localparam logic [7:0] kind_end     = 8'hFF;

    logic        i_clk;
    logic        i_reset;
    logic        i_instr_mem_empty;
    logic        i_instr_mem_full;
    logic        i_program_end;
    logic        i_uart_rd_end;
    logic        i_uart_wr_end;
    logic        i_reg_print_end;
    word_t       i_uart_rd_data;
    logic        o_start_uart_rd;
    logic        o_start_uart_wr;
    word_t       o_uart_wr_data;
    logic        o_start_reg_print;
    logic        o_mips_flush;
    logic        o_mips_clear_program;
    logic        o_mips_enabled;
    logic        o_mips_instr_wr;
    word_t       o_mips_instr;
    word_t       o_cycle_count;

    logic [39:0] cases [0:case_depth-1];
    logic [31:0] lfsr_state;
    int          n_cases;
    int          cycle_total;
    int          cycle_limit;
    int          writes_seen;
    int          writes_expected;
    int          flush_seen;
    int          flush_expected;
    int          prints_seen;
    int          prints_expected;
    int          prints_answered;
    int          steps;
    logic        stepping;
    logic        print_prev;

    debug_control_top u_debug_control_top (
        .i_clk                (i_clk),
        .i_reset              (i_reset),
        .i_instr_mem_empty    (i_instr_mem_empty),
        .i_instr_mem_full     (i_instr_mem_full),
        .i_program_end        (i_program_end),
        .i_uart_rd_end        (i_uart_rd_end),
        .i_uart_wr_end        (i_uart_wr_end),
        .i_reg_print_end      (i_reg_print_end),
        .i_uart_rd_data       (i_uart_rd_data),
        .o_start_uart_rd      (o_start_uart_rd),
        .o_start_uart_wr      (o_start_uart_wr),
        .o_uart_wr_data       (o_uart_wr_data),
        .o_start_reg_print    (o_start_reg_print),
        .o_mips_flush         (o_mips_flush),
        .o_mips_clear_program (o_mips_clear_program),
        .o_mips_enabled       (o_mips_enabled),
        .o_mips_instr_wr      (o_mips_instr_wr),
        .o_mips_instr         (o_mips_instr),
        .o_cycle_count        (o_cycle_count)
    );

    initial
    begin
        i_clk = 1'b0;
        forever
            #20 i_clk = ~i_clk;
    end

    task automatic fail_run();
        $display("Test failures found");
        $fatal(1, "Simulation stopped at the first failure.");
    endtask

    // Galois form with taps for x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        logic [31:0] next;
        next = {1'b0, state[31:1]};
        if (state[0])
            next = next ^ 32'h8020_0003;
        return next;
    endfunction

    function automatic int random_bits(input int count);
        int bits;
        bits = 0;
        for (int i = 0; i < count; i++)
        begin
            lfsr_state = lfsr_step(lfsr_state);
            bits = (bits << 1) | int'(lfsr_state[0]);
        end
        return bits;
    endfunction

    task automatic compare_status(input word_t got, input word_t want);
        if (got !== want)
        begin
            $display("FAILED at %0t: o_uart_wr_data is %h, expected %h", $time, got, want);
            fail_run();
        end
    endtask

    task automatic compare_instr(input word_t got, input word_t want);
        if (got !== want)
        begin
            $display("FAILED at %0t: o_mips_instr is %h, expected %h", $time, got, want);
            fail_run();
        end
    endtask

    task automatic compare_cycles(input word_t got, input word_t want);
        if (got !== want)
        begin
            $display("FAILED at %0t: o_cycle_count is %h, expected %h", $time, got, want);
            fail_run();
        end
    endtask

    task automatic expect_level(input logic got, input logic want, input string name);
        if (got !== want)
        begin
            $display("FAILED at %0t: %s is %b, expected %b", $time, name, got, want);
            fail_run();
        end
    endtask

    task automatic expect_tally(input int got, input int want, input string name);
        if (got != want)
        begin
            $display("FAILED at %0t: %s count is %0d, expected %0d", $time, name, got, want);
            fail_run();
        end
    endtask

    // Outputs are sampled and inputs are driven on the falling edge.
    task automatic tick();
        @(negedge i_clk);
        cycle_total++;
        if (cycle_total > cycle_limit)
        begin
            $display("Timeout: the DUT did not respond within %0d cycles.", cycle_limit);
            fail_run();
        end
        if (o_mips_instr_wr)
            writes_seen++;
        if (o_mips_flush)
            flush_seen++;
        if (o_start_reg_print && !print_prev)
            prints_seen++;
        print_prev = o_start_reg_print;
    endtask

    function automatic logic start_level(input int unit);
        case (unit)
            unit_rd: return o_start_uart_rd;
            unit_wr: return o_start_uart_wr;
            default: return o_start_reg_print;
        endcase
    endfunction

    function automatic string unit_name(input int unit);
        case (unit)
            unit_rd: return "o_start_uart_rd";
            unit_wr: return "o_start_uart_wr";
            default: return "o_start_reg_print";
        endcase
    endfunction

    task automatic drive_end(input int unit, input logic level);
        case (unit)
            unit_rd: i_uart_rd_end   = level;
            unit_wr: i_uart_wr_end   = level;
            default: i_reg_print_end = level;
        endcase
    endtask

    task automatic expect_quiet();
        expect_level(o_start_uart_rd, 1'b0, "o_start_uart_rd");
        expect_level(o_start_uart_wr, 1'b0, "o_start_uart_wr");
        expect_level(o_start_reg_print, 1'b0, "o_start_reg_print");
        expect_level(o_mips_flush, 1'b0, "o_mips_flush");
        expect_level(o_mips_clear_program, 1'b0, "o_mips_clear_program");
        expect_level(o_mips_enabled, 1'b0, "o_mips_enabled");
        expect_level(o_mips_instr_wr, 1'b0, "o_mips_instr_wr");
    endtask

    task automatic wait_start(input int unit);
        while (!start_level(unit))
        begin
            tick();
            for (int other = 0; other < 3; other++)
            begin
                if (other != unit && start_level(other))
                begin
                    $display("Unexpected %s rise at %0t while waiting for %s.",
                             unit_name(other), $time, unit_name(unit));
                    fail_run();
                end
            end
        end
    endtask

    // Entered on the falling edge where the strobe is first seen high.
    task automatic answer_start(input int unit);
        int delay;
        delay = 2 + random_bits(3);
        tick();
        expect_level(start_level(unit), 1'b1, unit_name(unit));
        tick();
        expect_level(start_level(unit), 1'b0, unit_name(unit));
        repeat (delay - 2)
            tick();
        drive_end(unit, 1'b1);
        tick();
        drive_end(unit, 1'b0);
    endtask

    task automatic wait_flush(input logic with_clear);
        while (!o_mips_flush)
            tick();
        expect_level(o_mips_clear_program, with_clear, "o_mips_clear_program");
        tick();
        expect_level(o_mips_flush, 1'b0, "o_mips_flush");
        expect_level(o_mips_clear_program, 1'b0, "o_mips_clear_program");
        flush_expected++;
    endtask

    task automatic wait_single_step();
        while (!o_mips_enabled)
            tick();
        tick();
        expect_level(o_mips_enabled, 1'b0, "o_mips_enabled");
        steps++;
        prints_expected++;  // Registers are printed after every step.
    endtask

    task automatic send_command(input logic [7:0] cmd);
        wait_start(unit_rd);
        if (stepping)
            compare_cycles(o_cycle_count, word_t'(steps + 1));
        else
            compare_cycles(o_cycle_count, word_t'(1));
        i_uart_rd_data = word_t'(cmd);
        answer_start(unit_rd);
        if (stepping)
        begin
            if (cmd == `DBG_CMD_N)
                wait_single_step();
            else if (cmd == `DBG_CMD_S)
                stepping = 1'b0;
        end
        else
        begin
            case (cmd)
                `DBG_CMD_L, `DBG_CMD_F: wait_flush(1'b1);
                `DBG_CMD_E: wait_flush(1'b0);
                `DBG_CMD_S:
                begin
                    wait_flush(1'b0);
                    stepping = 1'b1;
                    steps    = 0;
                    prints_expected++;
                end
                default: ;  // An unknown byte is answered with an error word.
            endcase
        end
    endtask

    task automatic send_load_word(input word_t word);
        wait_start(unit_rd);
        i_uart_rd_data = word;
        answer_start(unit_rd);
        while (!o_mips_instr_wr)
            tick();
        compare_instr(o_mips_instr, word);
        tick();
        expect_level(o_mips_instr_wr, 1'b0, "o_mips_instr_wr");
        writes_expected++;
    endtask

    task automatic run_core(input int length);
        while (!o_mips_enabled)
            tick();
        repeat (length - 1)
        begin
            tick();
            expect_level(o_mips_enabled, 1'b1, "o_mips_enabled");
        end
        i_program_end = 1'b1;  // Held until the end-of-program word.
        prints_expected++;
    endtask

    task automatic expect_status(input word_t want);
        while (prints_answered < prints_expected)
        begin
            wait_start(unit_print);
            answer_start(unit_print);
            prints_answered++;
        end
        wait_start(unit_wr);
        compare_status(o_uart_wr_data, want);
        expect_level(o_mips_enabled, 1'b0, "o_mips_enabled");
        expect_tally(prints_seen, prints_expected, "o_start_reg_print rise");
        expect_tally(writes_seen, writes_expected, "o_mips_instr_wr pulse");
        expect_tally(flush_seen, flush_expected, "o_mips_flush cycle");
        i_program_end = 1'b0;
        answer_start(unit_wr);
    endtask

    task automatic run_case(input logic [39:0] entry);
        logic [7:0] kind;
        word_t      value;
        kind  = entry[39:32];
        value = entry[31:0];
        case (kind)
            kind_command: send_command(value[7:0]);
            kind_load:    send_load_word(value);
            kind_levels:
            begin
                i_instr_mem_empty = value[0];
                i_instr_mem_full  = value[1];
            end
            kind_run:     run_core(int'(value));
            kind_status:  expect_status(value);
            default:
            begin
                $display("Case entry %h has an unknown kind.", entry);
                fail_run();
            end
        endcase
    endtask

    initial
    begin
        i_reset           = 1'b1;
        i_instr_mem_empty = 1'b0;
        i_instr_mem_full  = 1'b0;
        i_program_end     = 1'b0;
        i_uart_rd_end     = 1'b0;
        i_uart_wr_end     = 1'b0;
        i_reg_print_end   = 1'b0;
        i_uart_rd_data    = '0;
        lfsr_state        = 32'h1359;
        cycle_total       = 0;
        writes_seen       = 0;
        writes_expected   = 0;
        flush_seen        = 0;
        flush_expected    = 0;
        prints_seen       = 0;
        prints_expected   = 0;
        prints_answered   = 0;
        steps             = 0;
        stepping          = 1'b0;
        print_prev        = 1'b0;

        for (int i = 0; i < case_depth; i++)
            cases[i[5:0]] = {kind_end, 32'(i)};  // Unused entries end the list.
        $readmemh("dv/debug_cases.txt", cases);
        n_cases = 0;
        while (n_cases < case_depth && cases[n_cases[5:0]][39:32] != kind_end)
            n_cases++;
        cycle_limit = 400 * n_cases + 64;

        repeat (10)
        begin
            tick();
            expect_quiet();
            compare_cycles(o_cycle_count, '0);
        end
        i_reset = 1'b0;
        tick();
        expect_quiet();
        tick();
        expect_level(o_start_uart_rd, 1'b1, "o_start_uart_rd");  // Reset, then idle.

        for (int line = 0; line < n_cases; line++)
            run_case(cases[line[5:0]]);

        // The controller is back in idle and asks for the next command.
        wait_start(unit_rd);
        compare_cycles(o_cycle_count, word_t'(1));
        expect_tally(prints_seen, prints_expected, "o_start_reg_print rise");
        expect_tally(writes_seen, writes_expected, "o_mips_instr_wr pulse");
        expect_tally(flush_seen, flush_expected, "o_mips_flush cycle");

        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+include
rtl/debug_pkg.sv
rtl/debug_ctl_if.sv
rtl/debug_sequencer.sv
rtl/debug_status_regs.sv
rtl/debug_control_top.sv
dv/tb_debug_control.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the debug controller testbench with Verilator and run it.
set -e

cd "$(dirname "$0")"

verilator --binary -j 0 \
    --timescale 1ns/10ps \
    --top-module tb_debug_control \
    -Mdir obj_dir \
    -o sim_debug_control \
    -f project.f

./obj_dir/sim_debug_control

// ==== dv/debug_cases.txt ====
// Columns: kind byte, then a 32-bit value, one hex number per line.
// Kinds: 01 command byte, 02 load word, 03 memory levels (bit 0 empty, bit 1 full),
// 04 enabled cycles before program end, 05 expected status word.
0300000000
010000004C  // Load.
0224080005
02240900FF
0201095020
02AD0A0004
02FFFFFFFF  // HALT.
0549000001  // Load done.
0100000045  // Run.
0400000006
0549000002  // End of program.
0100000053  // Step mode.
0549000003
010000004E  // Next step.
0549000003
0100000051  // Not a step command.
0545000004
010000004E
0549000003
0100000053  // Leave step mode.
0100000058  // Unknown command.
0545000004
0100000046  // Flush.
0100000045
0400000001  // Single-cycle run.
0549000002
0300000001  // Memory empty.
0100000045
0545000006  // Empty program.
0300000002  // Memory full.
010000004C
0545000005  // Memory full.
0300000000
0100000046
